// File: nfc_config.svh
`ifndef NFC_CONFIG_SVH
`define NFC_CONFIG_SVH

// flash ways, one chip enable per way
`define NFC_NUM_WAYS 4

// write enable phase lengths in system clocks
`define NFC_WE_LOW_CYCLES 2
`define NFC_WE_HIGH_CYCLES 2

// widths
`define NFC_CA_BYTES 5
`define NFC_WORD_BITS 16
`define NFC_DQ_BITS 8

`endif

// File: nfc_pkg.sv
`include "nfc_config.svh"

package nfc_pkg;

    // one-hot command code, all zero is no command
    typedef logic [1:0] commandT;

    localparam commandT CmdCaLatch = 2'b01;
    localparam commandT CmdDataOut = 2'b10;

    typedef enum logic [2:0] {
        Idle,
        WaitData,
        WeLow,
        WeHigh,
        Finish
    } fsmStateT;

    // one byte on the flash bus
    typedef logic [`NFC_DQ_BITS-1:0] dqByteT;

endpackage

// File: nfcStepFsm.sv
`timescale 1ns/1ps

module nfcStepFsm (
    input  logic             systemClock,
    input  logic             arstN,
    input  nfc_pkg::commandT command,
    input  logic             caSelect,
    input  logic             phaseDone,
    input  logic             lastByte,
    input  logic             byteAvailable,
    output logic             load,
    output logic             dataMode,
    output logic             weLowPhase,
    output logic             weHighPhase,
    output logic             byteAdvance,
    output logic [1:0]       latchMode,
    output logic             ready,
    output logic             lastStep
);
    import nfc_pkg::*;

    fsmStateT state;
    fsmStateT nextState;
    logic     isDataCmd;
    logic     dataOp;
    logic     addrSel;
    logic     opActive;

    // only a clean one-hot code starts an operation
    assign isDataCmd = (command == CmdDataOut);
    assign load      = (state == Idle) && ((command == CmdCaLatch) || isDataCmd);

    assign ready       = (state == Idle);
    assign lastStep    = (state == Finish);
    assign weLowPhase  = (state == WeLow);
    assign weHighPhase = (state == WeHigh);
    assign byteAdvance = weHighPhase && phaseDone;
    assign opActive    = (state == WaitData) || weLowPhase || weHighPhase;

    // in Idle the mode follows the strobe so the timer loads the right count
    assign dataMode = (state == Idle) ? isDataCmd : (dataOp && opActive);

    // bit 0 command latch, bit 1 address latch
    assign latchMode = (opActive && !dataOp) ? (addrSel ? 2'b10 : 2'b01) : 2'b00;

    always_comb begin
        nextState = state;
        unique case (state)
            Idle: begin
                if (load) begin
                    nextState = isDataCmd ? WaitData : WeLow;
                end
            end
            WaitData: begin
                if (byteAvailable) begin
                    nextState = WeLow;
                end
            end
            WeLow: begin
                if (phaseDone) begin
                    nextState = WeHigh;
                end
            end
            WeHigh: begin
                if (phaseDone) begin
                    if (lastByte) begin
                        nextState = Finish;
                    end else begin
                        nextState = dataOp ? WaitData : WeLow;
                    end
                end
            end
            Finish: nextState = Idle;
            default: nextState = Idle;
        endcase
    end

    always_ff @(posedge systemClock or negedge arstN) begin
        if (!arstN) begin
            state   <= Idle;
            dataOp  <= 1'b0;
            addrSel <= 1'b0;
        end else begin
            state <= nextState;
            // operation kind held for the whole run
            if (load) begin
                dataOp  <= isDataCmd;
                addrSel <= caSelect;
            end
        end
    end

endmodule

// File: nfcCycleTimer.sv
`timescale 1ns/1ps
`include "nfc_config.svh"

module nfcCycleTimer (
    input  logic        systemClock,
    input  logic        arstN,
    input  logic        load,
    input  logic        dataMode,
    input  logic [15:0] numOfData,
    input  logic        weLowPhase,
    input  logic        weHighPhase,
    input  logic        byteAdvance,
    output logic        phaseDone,
    output logic        lastByte
);
    localparam int MaxPhase  = (`NFC_WE_LOW_CYCLES > `NFC_WE_HIGH_CYCLES) ?
                               `NFC_WE_LOW_CYCLES : `NFC_WE_HIGH_CYCLES;
    localparam int PhaseBits = $clog2(MaxPhase + 1);
    // twice a 16-bit word count
    localparam int CountBits = 17;

    logic [PhaseBits-1:0] phaseCnt;
    logic [CountBits-1:0] remaining;
    logic [CountBits-1:0] loadCount;
    logic [2:0]           caCount;

    assign phaseDone = (weLowPhase && (phaseCnt == PhaseBits'(`NFC_WE_LOW_CYCLES - 1))) ||
                       (weHighPhase && (phaseCnt == PhaseBits'(`NFC_WE_HIGH_CYCLES - 1)));

    // a zero count still ends after one byte
    assign lastByte = (remaining <= CountBits'(1));

    // ca byte count clamped to 1..max
    always_comb begin
        caCount = numOfData[2:0];
        if (caCount == 3'd0) begin
            caCount = 3'd1;
        end else if (caCount > 3'(`NFC_CA_BYTES)) begin
            caCount = 3'(`NFC_CA_BYTES);
        end
        loadCount = dataMode ? {numOfData, 1'b0} : CountBits'(caCount);
    end

    always_ff @(posedge systemClock or negedge arstN) begin
        if (!arstN) begin
            phaseCnt  <= '0;
            remaining <= '0;
        end else begin
            if ((weLowPhase || weHighPhase) && !phaseDone) begin
                phaseCnt <= phaseCnt + 1'b1;
            end else begin
                phaseCnt <= '0;
            end
            if (load) begin
                remaining <= loadCount;
            end else if (byteAdvance) begin
                remaining <= remaining - 1'b1;
            end
        end
    end

endmodule

// File: nfcCaShifter.sv
`timescale 1ns/1ps
`include "nfc_config.svh"

module nfcCaShifter (
    input  logic                                  systemClock,
    input  logic                                  arstN,
    input  logic                                  load,
    input  logic [`NFC_CA_BYTES*`NFC_DQ_BITS-1:0] caData,
    input  logic                                  byteAdvance,
    output nfc_pkg::dqByteT                       caByte
);
    localparam int CaBits = `NFC_CA_BYTES * `NFC_DQ_BITS;

    logic [CaBits-1:0] caReg;

    // current byte always sits at the bottom
    assign caByte = caReg[`NFC_DQ_BITS-1:0];

    always_ff @(posedge systemClock or negedge arstN) begin
        if (!arstN) begin
            caReg <= '0;
        end else if (load) begin
            caReg <= caData;
        end else if (byteAdvance) begin
            caReg <= caReg >> `NFC_DQ_BITS;
        end
    end

endmodule

// File: nfcWriteDataPath.sv
`timescale 1ns/1ps
`include "nfc_config.svh"

module nfcWriteDataPath (
    input  logic                      systemClock,
    input  logic                      arstN,
    input  logic                      dataMode,
    input  logic [`NFC_WORD_BITS-1:0] writeData,
    input  logic                      writeValid,
    output logic                      writeReady,
    input  logic                      byteAdvance,
    output logic                      byteAvailable,
    output nfc_pkg::dqByteT           dataByte
);
    logic [`NFC_WORD_BITS-1:0] word;
    logic                      full;
    logic                      highHalf;

    // accept a new word only when the previous one is fully sent
    assign writeReady    = dataMode && !full;
    assign byteAvailable = full;

    // low byte first, then high byte
    assign dataByte = highHalf ? word[`NFC_DQ_BITS +: `NFC_DQ_BITS] : word[0 +: `NFC_DQ_BITS];

    always_ff @(posedge systemClock) begin
        if (writeValid && writeReady) begin
            word <= writeData;
        end
    end

    always_ff @(posedge systemClock or negedge arstN) begin
        if (!arstN) begin
            full     <= 1'b0;
            highHalf <= 1'b0;
        end else if (writeValid && writeReady) begin
            full     <= 1'b1;
            highHalf <= 1'b0;
        end else if (byteAdvance && full) begin
            // word freed after its high byte
            if (highHalf) begin
                full     <= 1'b0;
                highHalf <= 1'b0;
            end else begin
                highHalf <= 1'b1;
            end
        end
    end

endmodule

// File: nfcPinDriver.sv
`timescale 1ns/1ps
`include "nfc_config.svh"

module nfcPinDriver (
    input  logic                     systemClock,
    input  logic                     arstN,
    input  logic                     ready,
    input  logic [1:0]               latchMode,
    input  logic                     dataMode,
    input  logic                     weLowPhase,
    input  logic [`NFC_NUM_WAYS-1:0] targetWay,
    input  nfc_pkg::dqByteT          caByte,
    input  nfc_pkg::dqByteT          dataByte,
    output logic [`NFC_NUM_WAYS-1:0] chipEnableN,
    output logic                     commandLatchEnable,
    output logic                     addressLatchEnable,
    output logic                     writeEnableN,
    output nfc_pkg::dqByteT          dq,
    output logic                     dqOutEnable
);
    logic [`NFC_NUM_WAYS-1:0] heldWay;
    logic                     active;
    logic                     driveByte;

    // idle and finish both leave the bus released
    assign active    = !ready && ((|latchMode) || dataMode);
    assign driveByte = active && weLowPhase;

    // way follows the strobe while idle, frozen once started
    always_ff @(posedge systemClock) begin
        if (ready) begin
            heldWay <= targetWay;
        end
    end

    always_ff @(posedge systemClock or negedge arstN) begin
        if (!arstN) begin
            chipEnableN        <= '1;
            commandLatchEnable <= 1'b0;
            addressLatchEnable <= 1'b0;
            writeEnableN       <= 1'b1;
            dq                 <= '0;
            dqOutEnable        <= 1'b0;
        end else begin
            chipEnableN        <= active ? ~heldWay : '1;
            commandLatchEnable <= active && latchMode[0];
            addressLatchEnable <= active && latchMode[1];
            writeEnableN       <= !driveByte;
            dqOutEnable        <= active;
            // dq changes only while we is low, held through high and waits
            if (driveByte) begin
                dq <= dataMode ? dataByte : caByte;
            end
        end
    end

endmodule

// File: nfcAsyncWriteTop.sv
`timescale 1ns/1ps
`include "nfc_config.svh"

module nfcAsyncWriteTop (
    input  logic                                  systemClock,
    input  logic                                  arstN,
    input  nfc_pkg::commandT                      command,
    input  logic [`NFC_NUM_WAYS-1:0]              targetWay,
    input  logic [15:0]                           numOfData,
    input  logic                                  caSelect,
    input  logic [`NFC_CA_BYTES*`NFC_DQ_BITS-1:0] caData,
    input  logic [`NFC_WORD_BITS-1:0]             writeData,
    input  logic                                  writeValid,
    output logic                                  writeReady,
    output logic                                  ready,
    output logic                                  lastStep,
    output logic [`NFC_NUM_WAYS-1:0]              chipEnableN,
    output logic                                  commandLatchEnable,
    output logic                                  addressLatchEnable,
    output logic                                  writeEnableN,
    output nfc_pkg::dqByteT                       dq,
    output logic                                  dqOutEnable
);
    import nfc_pkg::*;

    // fsm control to the datapath blocks
    logic       load;
    logic       dataMode;
    logic       weLowPhase;
    logic       weHighPhase;
    logic       byteAdvance;
    logic [1:0] latchMode;

    // status back to the fsm
    logic       phaseDone;
    logic       lastByte;
    logic       byteAvailable;

    dqByteT     caByte;
    dqByteT     dataByte;

    nfcStepFsm i_nfcStepFsm (
        .systemClock   (systemClock),
        .arstN         (arstN),
        .command       (command),
        .caSelect      (caSelect),
        .phaseDone     (phaseDone),
        .lastByte      (lastByte),
        .byteAvailable (byteAvailable),
        .load          (load),
        .dataMode      (dataMode),
        .weLowPhase    (weLowPhase),
        .weHighPhase   (weHighPhase),
        .byteAdvance   (byteAdvance),
        .latchMode     (latchMode),
        .ready         (ready),
        .lastStep      (lastStep)
    );

    nfcCycleTimer i_nfcCycleTimer (
        .systemClock (systemClock),
        .arstN       (arstN),
        .load        (load),
        .dataMode    (dataMode),
        .numOfData   (numOfData),
        .weLowPhase  (weLowPhase),
        .weHighPhase (weHighPhase),
        .byteAdvance (byteAdvance),
        .phaseDone   (phaseDone),
        .lastByte    (lastByte)
    );

    nfcCaShifter i_nfcCaShifter (
        .systemClock (systemClock),
        .arstN       (arstN),
        .load        (load),
        .caData      (caData),
        .byteAdvance (byteAdvance),
        .caByte      (caByte)
    );

    nfcWriteDataPath i_nfcWriteDataPath (
        .systemClock   (systemClock),
        .arstN         (arstN),
        .dataMode      (dataMode),
        .writeData     (writeData),
        .writeValid    (writeValid),
        .writeReady    (writeReady),
        .byteAdvance   (byteAdvance),
        .byteAvailable (byteAvailable),
        .dataByte      (dataByte)
    );

    nfcPinDriver i_nfcPinDriver (
        .systemClock        (systemClock),
        .arstN              (arstN),
        .ready              (ready),
        .latchMode          (latchMode),
        .dataMode           (dataMode),
        .weLowPhase         (weLowPhase),
        .targetWay          (targetWay),
        .caByte             (caByte),
        .dataByte           (dataByte),
        .chipEnableN        (chipEnableN),
        .commandLatchEnable (commandLatchEnable),
        .addressLatchEnable (addressLatchEnable),
        .writeEnableN       (writeEnableN),
        .dq                 (dq),
        .dqOutEnable        (dqOutEnable)
    );

endmodule

// File: nfc_props.sv
`timescale 1ns/1ps
`include "nfc_config.svh"

module nfcProps (
    input logic systemClock,
    input logic arstN,
    input logic writeEnableN,
    input logic commandLatchEnable,
    input logic addressLatchEnable,
    input logic dqOutEnable
);
    import nfc_pkg::*;

    // clocks spent low in the current write enable pulse
    int lowCount;

    always_ff @(posedge systemClock or negedge arstN) begin
        if (!arstN) begin
            lowCount <= 0;
        end else if (!writeEnableN) begin
            lowCount <= lowCount + 1;
        end else begin
            lowCount <= 0;
        end
    end

    weLowLength: assert property (@(posedge systemClock) disable iff (!arstN)
        $rose(writeEnableN) |-> (lowCount == `NFC_WE_LOW_CYCLES))
        else $error("write enable low phase has the wrong length");

    latchExclusive: assert property (@(posedge systemClock) disable iff (!arstN)
        !(commandLatchEnable && addressLatchEnable))
        else $error("command and address latch enables high together");

    busDrivenOnWrite: assert property (@(posedge systemClock) disable iff (!arstN)
        !writeEnableN |-> dqOutEnable)
        else $error("write enable low while dq is not driven");

endmodule

bind nfcAsyncWriteTop nfcProps i_nfcProps (.*);

// File: nfcTb.sv
`timescale 1ns/1ps
`include "nfc_config.svh"

module nfcClockGen #(
    parameter int HalfPeriodNs = 50
) (
    output logic systemClock
);
    initial begin
        systemClock = 1'b0;
    end

    always #(HalfPeriodNs) systemClock = ~systemClock;

endmodule

module nfcTb;
    import nfc_pkg::*;

    localparam int Ways          = `NFC_NUM_WAYS;
    localparam int CaBits        = `NFC_CA_BYTES * `NFC_DQ_BITS;
    localparam int WordBits      = `NFC_WORD_BITS;
    localparam int PhaseSum      = `NFC_WE_LOW_CYCLES + `NFC_WE_HIGH_CYCLES;
    localparam int DriveDelay    = 10;
    // longest run is well under two hundred clocks
    localparam int TimeoutCycles = 2000;

    logic                systemClock;
    logic                arstN;
    commandT             command;
    logic [Ways-1:0]     targetWay;
    logic [15:0]         numOfData;
    logic                caSelect;
    logic [CaBits-1:0]   caData;
    logic [WordBits-1:0] writeData;
    logic                writeValid;
    logic                writeReady;
    logic                ready;
    logic                lastStep;
    logic [Ways-1:0]     chipEnableN;
    logic                commandLatchEnable;
    logic                addressLatchEnable;
    logic                writeEnableN;
    dqByteT              dq;
    logic                dqOutEnable;

    // expected bus bytes, {ale, cle, byte}
    logic [9:0]          expQ[$];
    logic [WordBits-1:0] words[$];
    logic [Ways-1:0]     expChipEnableN;
    logic [31:0]         lfsrState = 32'h190cb6a9;
    logic                prevWeN = 1'b1;
    int                  cycleCount = 0;
    int                  lastStepCount = 0;
    int                  lastStepCycle = 0;
    int                  weEdgeCount = 0;
    int                  valueErrors = 0;
    int                  otherErrors = 0;

    nfcClockGen i_nfcClockGen (
        .systemClock (systemClock)
    );

    nfcAsyncWriteTop i_nfcAsyncWriteTop (
        .systemClock        (systemClock),
        .arstN              (arstN),
        .command            (command),
        .targetWay          (targetWay),
        .numOfData          (numOfData),
        .caSelect           (caSelect),
        .caData             (caData),
        .writeData          (writeData),
        .writeValid         (writeValid),
        .writeReady         (writeReady),
        .ready              (ready),
        .lastStep           (lastStep),
        .chipEnableN        (chipEnableN),
        .commandLatchEnable (commandLatchEnable),
        .addressLatchEnable (addressLatchEnable),
        .writeEnableN       (writeEnableN),
        .dq                 (dq),
        .dqOutEnable        (dqOutEnable)
    );

    // fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit taken
    function automatic logic [31:0] lfsrBits(input int n);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < n; i++) begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            value     = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [Ways-1:0] randomWay();
        logic [Ways-1:0] one;
        one = 1;
        return one << lfsrBits($clog2(Ways));
    endfunction

    function automatic logic [CaBits-1:0] randomCa();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lfsrBits(32);
        lo = lfsrBits(32);
        return CaBits'({hi, lo});
    endfunction

    // expected byte list of one operation
    function automatic void buildExpected(input commandT cmd, input logic sel,
                                          input logic [CaBits-1:0] ca, input logic [15:0] num);
        int                n;
        logic [1:0]        kind;
        logic [CaBits-1:0] shifted;
        if (cmd == CmdCaLatch) begin
            n = int'(num[2:0]);
            if (n == 0) begin
                n = 1;
            end else if (n > `NFC_CA_BYTES) begin
                n = `NFC_CA_BYTES;
            end
            kind = sel ? 2'b10 : 2'b01;
            for (int i = 0; i < n; i++) begin
                shifted = ca >> (8 * i);
                expQ.push_back({kind, shifted[7:0]});
            end
        end else begin
            for (int i = 0; i < int'(num); i++) begin
                expQ.push_back({2'b00, words[i][7:0]});
                expQ.push_back({2'b00, words[i][15:8]});
            end
        end
    endfunction

    task automatic expectValue(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            valueErrors++;
            $display("ERR %0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic checkIdle();
        expectValue("ready", 1, 32'(ready));
        expectValue("writeReady", 0, 32'(writeReady));
        expectValue("lastStep", 0, 32'(lastStep));
        expectValue("writeEnableN", 1, 32'(writeEnableN));
        expectValue("chipEnableN", {32{1'b1}} >> (32 - Ways), 32'(chipEnableN));
        expectValue("commandLatchEnable", 0, 32'(commandLatchEnable));
        expectValue("addressLatchEnable", 0, 32'(addressLatchEnable));
        expectValue("dqOutEnable", 0, 32'(dqOutEnable));
    endtask

    task automatic nextCycle();
        @(posedge systemClock);
        #(DriveDelay);
    endtask

    // random gap before each word, hold valid until taken
    task automatic sendWords();
        int   gap;
        logic accepted;
        foreach (words[i]) begin
            gap = int'(lfsrBits(2));
            repeat (gap) nextCycle();
            writeValid = 1'b1;
            writeData  = words[i];
            accepted   = 1'b0;
            while (!accepted) begin
                @(negedge systemClock);
                accepted = writeReady;
                nextCycle();
            end
            writeValid = 1'b0;
        end
    endtask

    // a second start while busy must be dropped
    task automatic strobeWhileBusy();
        repeat (2) nextCycle();
        assert (!ready) else begin
            otherErrors++;
            $display("DUT was already idle when the busy strobe was driven");
        end
        command   = CmdDataOut;
        numOfData = 16'd4;
        caSelect  = 1'b0;
        caData    = randomCa();
        targetWay = randomWay();
        nextCycle();
        command = CmdCaLatch;
        nextCycle();
        command = '0;
    endtask

    task automatic runOperation(input commandT cmd, input logic sel, input logic [15:0] num,
                                input logic [CaBits-1:0] ca, input bit timed, input bit intrude);
        logic [Ways-1:0] way;
        int              expBytes;
        int              startCycle;
        int              edgesBefore;
        int              stepsBefore;
        way = randomWay();
        buildExpected(cmd, sel, ca, num);
        expBytes       = expQ.size();
        expChipEnableN = ~way;
        edgesBefore    = weEdgeCount;
        stepsBefore    = lastStepCount;
        startCycle     = cycleCount;
        command        = cmd;
        caSelect       = sel;
        numOfData      = num;
        caData         = ca;
        targetWay      = way;
        nextCycle();
        command   = '0;
        // way must stay as captured at the strobe
        targetWay = ~way;
        if (cmd == CmdDataOut) begin
            sendWords();
        end
        if (intrude) begin
            strobeWhileBusy();
        end
        wait (lastStepCount != stepsBefore);
        if (timed) begin
            expectValue("lastStep cycle", startCycle + 1 + expBytes * PhaseSum, lastStepCycle);
        end
        nextCycle();
        checkIdle();
        repeat (4) nextCycle();
        expectValue("write enable rising edges", expBytes, weEdgeCount - edgesBefore);
        expectValue("lastStep pulses", 1, lastStepCount - stepsBefore);
        assert (expQ.size() == 0) else begin
            otherErrors++;
            $display("%0d expected bytes were never sent", expQ.size());
            expQ.delete();
        end
    endtask

    // pins are sampled mid-cycle where they are stable
    always @(negedge systemClock) begin : pinMonitor
        logic [9:0] entry;
        if (arstN) begin
            if (lastStep) begin
                lastStepCount++;
                lastStepCycle = cycleCount;
            end
            if (dqOutEnable) begin
                expectValue("chipEnableN", 32'(expChipEnableN), 32'(chipEnableN));
            end
            // flash takes the byte on the write enable rising edge
            if (!prevWeN && writeEnableN) begin
                weEdgeCount++;
                expectValue("dqOutEnable", 1, 32'(dqOutEnable));
                assert (expQ.size() > 0) else begin
                    otherErrors++;
                    $display("write enable pulsed with no byte left to send at %0t", $time);
                end
                if (expQ.size() > 0) begin
                    entry = expQ.pop_front();
                    expectValue("dq", 32'(entry[7:0]), 32'(dq));
                    expectValue("commandLatchEnable", 32'(entry[8]), 32'(commandLatchEnable));
                    expectValue("addressLatchEnable", 32'(entry[9]), 32'(addressLatchEnable));
                end
            end
        end
        prevWeN = writeEnableN;
    end

    always @(posedge systemClock) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            otherErrors++;
            $display("timeout, the tests did not finish within %0d clocks", TimeoutCycles);
            $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        arstN      = 1'b0;
        command    = '0;
        targetWay  = '0;
        numOfData  = '0;
        caSelect   = 1'b0;
        caData     = '0;
        writeData  = '0;
        writeValid = 1'b0;
        repeat (3) @(posedge systemClock);
        #(DriveDelay);
        arstN = 1'b1;
        checkIdle();
        expectValue("dq", 0, 32'(dq));
        nextCycle();

        // single command byte, then five address bytes
        runOperation(CmdCaLatch, 1'b0, 16'd1, randomCa(), 1'b1, 1'b0);
        runOperation(CmdCaLatch, 1'b1, 16'd5, randomCa(), 1'b1, 1'b0);
        // count above five is clamped
        runOperation(CmdCaLatch, 1'b1, 16'd7, randomCa(), 1'b1, 1'b0);

        words.delete();
        for (int i = 0; i < 6; i++) begin
            words.push_back(WordBits'(lfsrBits(WordBits)));
        end
        runOperation(CmdDataOut, 1'b0, 16'd6, randomCa(), 1'b0, 1'b0);

        runOperation(CmdCaLatch, 1'b1, 16'd3, randomCa(), 1'b1, 1'b1);

        $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
nfc_pkg.sv
nfcStepFsm.sv
nfcCycleTimer.sv
nfcCaShifter.sv
nfcWriteDataPath.sv
nfcPinDriver.sv
nfcAsyncWriteTop.sv
nfc_props.sv
nfcTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module nfcTb -f files.f -o nfcSim

./obj_dir/nfcSim 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
